// File: verilog/tea_pkg.sv
package tea_pkg;

    // One cipher word, used for both block halves and key words
    typedef logic [31:0] word_t;

    // Loadable words in the order the panel collects them
    typedef enum logic [2:0] {
        slot_v0 = 3'd0,
        slot_v1 = 3'd1,
        slot_k0 = 3'd2,
        slot_k1 = 3'd3,
        slot_k2 = 3'd4,
        slot_k3 = 3'd5
    } slot_t;

    // TEA key schedule constant, added to the round sum once per round
    localparam word_t tea_delta = 32'h9e3779b9;

endpackage

// File: verilog/panel_sequencer.sv
`timescale 1ns/1ps

module panel_sequencer (
    input  logic              clk,
    input  logic              resetn,
    input  logic              go,
    input  logic              decrypt,
    input  logic              done,
    output logic              load_en,
    output tea_pkg::slot_t    load_slot,
    output logic              enc_start,
    output logic              dec_start,
    output logic              clear
);

    // Each word has a press state (register follows the switches)
    // and a release state (word held, waiting for go to drop)
    typedef enum logic [4:0] {
        s_v0,
        s_v0_rel,
        s_v1,
        s_v1_rel,
        s_k0,
        s_k0_rel,
        s_k1,
        s_k1_rel,
        s_k2,
        s_k2_rel,
        s_k3,
        s_k3_rel,
        s_wait_enc,
        s_enc_run,
        s_wait_dec,
        s_dec_run,
        s_wait_clr,
        s_clr_rel
    } state_t;

    state_t state, state_next;

    always_comb begin
        state_next = state;
        case (state)
            s_v0:       if (go) state_next = s_v0_rel;
            s_v0_rel:   if (!go) state_next = s_v1;
            s_v1:       if (go) state_next = s_v1_rel;
            s_v1_rel:   if (!go) state_next = s_k0;
            s_k0:       if (go) state_next = s_k0_rel;
            s_k0_rel:   if (!go) state_next = s_k1;
            s_k1:       if (go) state_next = s_k1_rel;
            s_k1_rel:   if (!go) state_next = s_k2;
            s_k2:       if (go) state_next = s_k2_rel;
            s_k2_rel:   if (!go) state_next = s_k3;
            s_k3:       if (go) state_next = s_k3_rel;
            s_k3_rel:   if (!go) state_next = s_wait_enc;
            s_wait_enc: if (go) state_next = s_enc_run;
            // Button presses are ignored until the engine reports done
            s_enc_run:  if (done) state_next = s_wait_dec;
            s_wait_dec: if (decrypt) state_next = s_dec_run;
            s_dec_run:  if (done) state_next = s_wait_clr;
            s_wait_clr: if (go) state_next = s_clr_rel;
            s_clr_rel:  if (!go) state_next = s_v0;
            default:    state_next = s_v0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= s_v0;
            enc_start <= 1'b0;
            dec_start <= 1'b0;
            clear     <= 1'b0;
        end else begin
            state     <= state_next;
            // Pulses land one cycle after the button is seen
            enc_start <= (state == s_wait_enc) && go;
            dec_start <= (state == s_wait_dec) && decrypt;
            clear     <= (state == s_wait_clr) && go;
        end
    end

    // Slot follows the state pair it belongs to
    always_comb begin
        case (state)
            s_v1, s_v1_rel: load_slot = tea_pkg::slot_v1;
            s_k0, s_k0_rel: load_slot = tea_pkg::slot_k0;
            s_k1, s_k1_rel: load_slot = tea_pkg::slot_k1;
            s_k2, s_k2_rel: load_slot = tea_pkg::slot_k2;
            s_k3, s_k3_rel: load_slot = tea_pkg::slot_k3;
            default:        load_slot = tea_pkg::slot_v0;
        endcase
    end

    assign load_en = (state == s_v0) || (state == s_v1) || (state == s_k0) ||
                     (state == s_k1) || (state == s_k2) || (state == s_k3);

endmodule

// File: verilog/tea_regs.sv
`timescale 1ns/1ps

module tea_regs #(
    parameter int data_in_w = 10
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [data_in_w-1:0]  data_in,
    input  logic                  load_en,
    input  tea_pkg::slot_t        load_slot,
    input  logic                  clear,
    input  logic                  wr_v0_en,
    input  logic                  wr_v1_en,
    input  tea_pkg::word_t        wr_data,
    output tea_pkg::word_t        v0,
    output tea_pkg::word_t        v1,
    output tea_pkg::word_t        k0,
    output tea_pkg::word_t        k1,
    output tea_pkg::word_t        k2,
    output tea_pkg::word_t        k3
);

    // Indexed by slot, block halves first then the key
    tea_pkg::word_t regs [6];

    always_ff @(posedge clk) begin
        if (!resetn || clear) begin
            for (int i = 0; i < 6; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Panel words are narrower than a cipher word
            if (load_en) begin
                regs[load_slot] <= tea_pkg::word_t'(data_in);
            end
            // Engine writes only happen while the panel is not loading
            if (wr_v0_en) begin
                regs[tea_pkg::slot_v0] <= wr_data;
            end
            if (wr_v1_en) begin
                regs[tea_pkg::slot_v1] <= wr_data;
            end
        end
    end

    assign v0 = regs[tea_pkg::slot_v0];
    assign v1 = regs[tea_pkg::slot_v1];
    assign k0 = regs[tea_pkg::slot_k0];
    assign k1 = regs[tea_pkg::slot_k1];
    assign k2 = regs[tea_pkg::slot_k2];
    assign k3 = regs[tea_pkg::slot_k3];

endmodule

// File: verilog/tea_engine.sv
`timescale 1ns/1ps

module tea_engine #(
    parameter int rounds = 32
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            enc_start,
    input  logic            dec_start,
    input  logic            clear,
    input  tea_pkg::word_t  v0,
    input  tea_pkg::word_t  v1,
    input  tea_pkg::word_t  k0,
    input  tea_pkg::word_t  k1,
    input  tea_pkg::word_t  k2,
    input  tea_pkg::word_t  k3,
    output logic            wr_v0_en,
    output logic            wr_v1_en,
    output tea_pkg::word_t  wr_data,
    output logic            done,
    output tea_pkg::word_t  display
);

    localparam int cnt_w = $clog2(rounds + 1);
    // Sum after all encrypt rounds, where decryption begins
    localparam tea_pkg::word_t dec_sum_init = tea_pkg::word_t'(tea_pkg::tea_delta * rounds);

    // Nine steps per round in either direction
    typedef enum logic [4:0] {
        st_idle,
        e_sum,
        e_terms0,
        e_key0,
        e_mix0,
        e_add0,
        e_terms1,
        e_key1,
        e_mix1,
        e_add1,
        d_terms0,
        d_key0,
        d_mix0,
        d_sub1,
        d_terms1,
        d_key1,
        d_mix1,
        d_sub0,
        d_sum
    } step_t;

    step_t              step, step_next;
    tea_pkg::word_t     sum;
    tea_pkg::word_t     term_shl;
    tea_pkg::word_t     term_sum;
    tea_pkg::word_t     term_shr;
    logic [cnt_w-1:0]   round_cnt;
    logic               last_round;
    logic               finish;
    tea_pkg::word_t     new_v1;

    assign last_round = (round_cnt == cnt_w'(rounds - 1));
    assign finish     = last_round && ((step == e_add1) || (step == d_sum));

    always_comb begin
        step_next = step;
        case (step)
            st_idle: begin
                if (enc_start) begin
                    step_next = e_sum;
                end else if (dec_start) begin
                    step_next = d_terms0;
                end
            end
            e_sum:    step_next = e_terms0;
            e_terms0: step_next = e_key0;
            e_key0:   step_next = e_mix0;
            e_mix0:   step_next = e_add0;
            e_add0:   step_next = e_terms1;
            e_terms1: step_next = e_key1;
            e_key1:   step_next = e_mix1;
            e_mix1:   step_next = e_add1;
            e_add1:   step_next = last_round ? st_idle : e_sum;
            d_terms0: step_next = d_key0;
            d_key0:   step_next = d_mix0;
            d_mix0:   step_next = d_sub1;
            d_sub1:   step_next = d_terms1;
            d_terms1: step_next = d_key1;
            d_key1:   step_next = d_mix1;
            d_mix1:   step_next = d_sub0;
            d_sub0:   step_next = d_sum;
            d_sum:    step_next = last_round ? st_idle : d_terms0;
            default:  step_next = st_idle;
        endcase
    end

    // Control, round sum and round count
    always_ff @(posedge clk) begin
        if (!resetn) begin
            step      <= st_idle;
            sum       <= '0;
            round_cnt <= '0;
        end else begin
            step <= step_next;
            if (step == st_idle) begin
                round_cnt <= '0;
                if (enc_start) begin
                    sum <= '0;
                end else if (dec_start) begin
                    sum <= dec_sum_init;
                end
            end
            if (step == e_sum) begin
                sum <= sum + tea_pkg::tea_delta;
            end
            if (step == d_sum) begin
                sum <= sum - tea_pkg::tea_delta;
            end
            if ((step == e_add1) || (step == d_sum)) begin
                round_cnt <= round_cnt + 1'b1;
            end
        end
    end

    // Partial terms: (w << 4) + ka, w + sum, (w >> 5) + kb
    always_ff @(posedge clk) begin
        case (step)
            e_terms0, d_terms1: begin
                term_shl <= v1 << 4;
                term_sum <= v1 + sum;
                term_shr <= v1 >> 5;
            end
            e_terms1, d_terms0: begin
                term_shl <= v0 << 4;
                term_sum <= v0 + sum;
                term_shr <= v0 >> 5;
            end
            e_key0, d_key1: begin
                term_shl <= term_shl + k0;
                term_shr <= term_shr + k1;
            end
            e_key1, d_key0: begin
                term_shl <= term_shl + k2;
                term_shr <= term_shr + k3;
            end
            e_mix0, e_mix1, d_mix0, d_mix1: begin
                term_shl <= term_shl ^ term_sum ^ term_shr;
            end
            default: begin
                term_shl <= term_shl;
            end
        endcase
    end

    assign wr_v0_en = (step == e_add0) || (step == d_sub0);
    assign wr_v1_en = (step == e_add1) || (step == d_sub1);

    always_comb begin
        case (step)
            e_add0:  wr_data = v0 + term_shl;
            e_add1:  wr_data = v1 + term_shl;
            d_sub1:  wr_data = v1 - term_shl;
            d_sub0:  wr_data = v0 - term_shl;
            default: wr_data = '0;
        endcase
    end

    // Encryption finishes on a v1 write, so pick up the word in flight
    assign new_v1 = wr_v1_en ? wr_data : v1;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            done    <= 1'b0;
            display <= '0;
        end else begin
            done <= finish;
            if (clear) begin
                display <= '0;
            end else if (finish) begin
                display <= {new_v1[15:0], v0[15:0]};
            end
        end
    end

endmodule

// File: verilog/crypt_machine.sv
`timescale 1ns/1ps

module crypt_machine #(
    parameter int data_in_w = 10,
    parameter int rounds    = 32
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [data_in_w-1:0]  data_in,
    input  logic                  go,
    input  logic                  decrypt,
    output tea_pkg::word_t        display
);

    logic            load_en;
    tea_pkg::slot_t  load_slot;
    logic            enc_start;
    logic            dec_start;
    logic            clear;
    logic            done;
    logic            wr_v0_en;
    logic            wr_v1_en;
    tea_pkg::word_t  wr_data;
    tea_pkg::word_t  v0, v1, k0, k1, k2, k3;

    // Front panel buttons to strobes and pulses
    panel_sequencer u_panel (
        .clk       (clk),
        .resetn    (resetn),
        .go        (go),
        .decrypt   (decrypt),
        .done      (done),
        .load_en   (load_en),
        .load_slot (load_slot),
        .enc_start (enc_start),
        .dec_start (dec_start),
        .clear     (clear)
    );

    tea_regs #(
        .data_in_w (data_in_w)
    ) u_regs (
        .clk       (clk),
        .resetn    (resetn),
        .data_in   (data_in),
        .load_en   (load_en),
        .load_slot (load_slot),
        .clear     (clear),
        .wr_v0_en  (wr_v0_en),
        .wr_v1_en  (wr_v1_en),
        .wr_data   (wr_data),
        .v0        (v0),
        .v1        (v1),
        .k0        (k0),
        .k1        (k1),
        .k2        (k2),
        .k3        (k3)
    );

    tea_engine #(
        .rounds (rounds)
    ) u_engine (
        .clk       (clk),
        .resetn    (resetn),
        .enc_start (enc_start),
        .dec_start (dec_start),
        .clear     (clear),
        .v0        (v0),
        .v1        (v1),
        .k0        (k0),
        .k1        (k1),
        .k2        (k2),
        .k3        (k3),
        .wr_v0_en  (wr_v0_en),
        .wr_v1_en  (wr_v1_en),
        .wr_data   (wr_data),
        .done      (done),
        .display   (display)
    );

endmodule

// File: bench/crypt_machine_assert.sv
`timescale 1ns/1ps

module crypt_machine_assert #(
    parameter int rounds = 32
) (
    input logic clk,
    input logic resetn,
    input logic enc_start,
    input logic dec_start,
    input logic clear,
    input logic done,
    input logic wr_v0_en,
    input logic wr_v1_en
);

    localparam int latency = rounds * 9 + 1;

    int   fail_count = 0;
    logic running;
    int   run_cycles;

    // Cycles since the last start pulse, while an operation is in flight
    always_ff @(posedge clk) begin
        if (!resetn) begin
            running    <= 1'b0;
            run_cycles <= 0;
        end else if (enc_start || dec_start) begin
            running    <= 1'b1;
            run_cycles <= 1;
        end else if (running) begin
            run_cycles <= run_cycles + 1;
            if (done) begin
                running <= 1'b0;
            end
        end
    end

    enc_pulse: assert property (@(posedge clk) disable iff (!resetn)
        enc_start |=> !enc_start)
        else begin
            fail_count++;
            $error("enc_start high for two cycles in a row");
        end

    dec_pulse: assert property (@(posedge clk) disable iff (!resetn)
        dec_start |=> !dec_start)
        else begin
            fail_count++;
            $error("dec_start high for two cycles in a row");
        end

    clear_pulse: assert property (@(posedge clk) disable iff (!resetn)
        clear |=> !clear)
        else begin
            fail_count++;
            $error("clear high for two cycles in a row");
        end

    done_pulse: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done)
        else begin
            fail_count++;
            $error("done high for two cycles in a row");
        end

    // Done lands exactly at the round latency, never earlier or later
    done_latency: assert property (@(posedge clk) disable iff (!resetn)
        done |-> (running && (run_cycles == latency)))
        else begin
            fail_count++;
            $error("done without a start pulse %0d cycles before", latency);
        end

    done_on_time: assert property (@(posedge clk) disable iff (!resetn)
        (running && (run_cycles == latency)) |-> done)
        else begin
            fail_count++;
            $error("done missing %0d cycles after the start pulse", latency);
        end

    quiet_writes: assert property (@(posedge clk) disable iff (!resetn)
        !running |-> !(wr_v0_en || wr_v1_en))
        else begin
            fail_count++;
            $error("engine write strobe while no operation runs");
        end

    single_op: assert property (@(posedge clk) disable iff (!resetn)
        running |-> !(enc_start || dec_start))
        else begin
            fail_count++;
            $error("start pulse while an operation is in flight");
        end

endmodule

bind crypt_machine crypt_machine_assert #(
    .rounds (rounds)
) assert_i (
    .clk       (clk),
    .resetn    (resetn),
    .enc_start (enc_start),
    .dec_start (dec_start),
    .clear     (clear),
    .done      (done),
    .wr_v0_en  (wr_v0_en),
    .wr_v1_en  (wr_v1_en)
);

// File: bench/crypt_machine_tb.sv
`timescale 1ns/1ps

module crypt_machine_tb;

    localparam int data_in_w = 10;
    localparam int rounds    = 32;
    localparam int runs      = 4;
    localparam int latency   = rounds * 9 + 1;
    localparam int timeout_cycles = runs * 2 * 300 + 400;
    localparam logic [31:0] delta = 32'h9e3779b9;
    localparam logic [31:0] word_mask = (32'd1 << data_in_w) - 32'd1;

    logic                  clk;
    logic                  resetn;
    logic [data_in_w-1:0]  data_in;
    logic                  go;
    logic                  decrypt;
    logic [31:0]           display;

    int seed;
    int value_errors = 0;
    int timeouts = 0;
    int cycle_count = 0;

    crypt_machine #(
        .data_in_w (data_in_w),
        .rounds    (rounds)
    ) dut_i (
        .clk     (clk),
        .resetn  (resetn),
        .data_in (data_in),
        .go      (go),
        .decrypt (decrypt),
        .display (display)
    );

    always #50 clk = ~clk;

    // Standard TEA, v0 in the low half of the result
    function automatic logic [63:0] ref_encrypt(input logic [31:0] a_in,
                                                input logic [31:0] b_in,
                                                input logic [127:0] key);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] s;
        a = a_in;
        b = b_in;
        s = '0;
        for (int i = 0; i < rounds; i++) begin
            s = s + delta;
            a = a + (((b << 4) + key[31:0]) ^ (b + s) ^ ((b >> 5) + key[63:32]));
            b = b + (((a << 4) + key[95:64]) ^ (a + s) ^ ((a >> 5) + key[127:96]));
        end
        return {b, a};
    endfunction

    function automatic logic [63:0] ref_decrypt(input logic [31:0] a_in,
                                                input logic [31:0] b_in,
                                                input logic [127:0] key);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] s;
        a = a_in;
        b = b_in;
        s = '0;
        for (int i = 0; i < rounds; i++) begin
            s = s + delta;
        end
        for (int i = 0; i < rounds; i++) begin
            b = b - (((a << 4) + key[95:64]) ^ (a + s) ^ ((a >> 5) + key[127:96]));
            a = a - (((b << 4) + key[31:0]) ^ (b + s) ^ ((b >> 5) + key[63:32]));
            s = s - delta;
        end
        return {b, a};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Fail at %0t ns: %s expected 0x%h got 0x%h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    // One full press and release of go with a word on the switches
    task automatic press_go(input logic [data_in_w-1:0] value);
        @(negedge clk);
        data_in = value;
        go = 1'b1;
        repeat (2) @(negedge clk);
        go = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    // Press a button, then count cycles from the start pulse to done
    task automatic run_engine(input bit use_decrypt, output int cycles);
        cycles = 0;
        @(negedge clk);
        if (use_decrypt) begin
            decrypt = 1'b1;
        end else begin
            go = 1'b1;
        end
        @(negedge clk);
        while (!(dut_i.enc_start || dut_i.dec_start)) begin
            @(negedge clk);
        end
        while (!dut_i.done) begin
            @(negedge clk);
            cycles++;
            // Button held a few cycles past the start pulse
            if (cycles == 3) begin
                go = 1'b0;
                decrypt = 1'b0;
            end
            // Stray presses in the middle of the run
            if (cycles == 100) begin
                go = 1'b1;
                decrypt = 1'b1;
            end
            if (cycles == 104) begin
                go = 1'b0;
                decrypt = 1'b0;
            end
        end
    endtask

    task automatic finish_run();
        int assert_errors;
        assert_errors = dut_i.assert_i.fail_count;
        $display("Errors: %0d value checks, %0d assertions, %0d timeouts",
                 value_errors, assert_errors, timeouts);
        if ((value_errors == 0) && (assert_errors == 0) && (timeouts == 0)) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("Timeout: no end of test after %0d cycles, the machine seems stuck",
                     timeout_cycles);
            timeouts = timeouts + 1;
            finish_run();
        end
    end

    initial begin
        logic [31:0]  words [6];
        logic [127:0] key;
        logic [63:0]  enc;
        logic [63:0]  dec;
        int           cycles;
        int           rnd;
        seed = 63101;
        clk = 1'b0;
        resetn = 1'b0;
        go = 1'b0;
        decrypt = 1'b0;
        data_in = '0;
        repeat (8) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        check_value("display after reset", 32'h0, display);

        for (int run = 0; run < runs; run++) begin
            // v0, v1, then k0 to k3
            for (int i = 0; i < 6; i++) begin
                rnd = $random(seed);
                words[i] = rnd & word_mask;
                press_go(words[i][data_in_w-1:0]);
            end
            key = {words[5], words[4], words[3], words[2]};
            enc = ref_encrypt(words[0], words[1], key);
            dec = ref_decrypt(enc[31:0], enc[63:32], key);

            run_engine(1'b0, cycles);
            check_value("encrypt latency", latency, cycles);
            check_value("display after encrypt", {enc[47:32], enc[15:0]}, display);

            run_engine(1'b1, cycles);
            check_value("decrypt latency", latency, cycles);
            check_value("display after decrypt", {dec[47:32], dec[15:0]}, display);

            press_go(words[0][data_in_w-1:0]);
            check_value("display after clear", 32'h0, display);
        end
        finish_run();
    end

endmodule

// File: build.f
verilog/tea_pkg.sv
verilog/panel_sequencer.sv
verilog/tea_regs.sv
verilog/tea_engine.sv
verilog/crypt_machine.sv
bench/crypt_machine_assert.sv
bench/crypt_machine_tb.sv

// File: run.sh
#!/bin/bash
# Compile with Verilator, run the testbench and check its log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module crypt_machine_tb -Mdir obj_dir -o crypt_sim \
    -f build.f > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

# Keep running past assertion errors so the testbench prints its summary
./obj_dir/crypt_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "Simulator exited with an error" >> sim.log
cat sim.log

! grep -q "sim failed" sim.log && grep -q "sim passed" sim.log && echo "Result: PASS" \
    || { echo "Result: FAIL"; exit 1; }
